// ==== build.f ====
fetch_pkg.sv
inst_ram.sv
fetch_mem_ctrl.sv
icache.sv
fetcher.sv
fetch_top.sv
tb_fetch.sv

// ==== fetch_mem_ctrl.sv ====
`default_nettype none

module fetch_mem_ctrl (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  req,
    input  fetch_pkg::addr_t     req_addr,
    input  wire                  drop,
    output fetch_pkg::ram_addr_t rd_addr,
    input  fetch_pkg::byte_t     rd_data,
    output logic                 fill_valid,
    output fetch_pkg::mem_fill_t fill
);

    fetch_pkg::mc_state_t state;
    // offset of the next byte address put on the RAM
    logic [2:0]           byte_cnt;
    fetch_pkg::addr_t     base_addr;
    fetch_pkg::inst_t     shift_word;

    // byte 0 goes out in the request cycle, the rest from the counter
    assign rd_addr = req ? req_addr[fetch_pkg::RAM_ADDR_BITS-1:0]
                         : base_addr[fetch_pkg::RAM_ADDR_BITS-1:0]
                           + fetch_pkg::ram_addr_t'(byte_cnt);

    assign fill = '{addr: base_addr, inst: shift_word};

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= fetch_pkg::MC_IDLE;
            byte_cnt   <= '0;
            fill_valid <= 1'b0;
        end else begin
            fill_valid <= 1'b0;
            if (req) begin
                // a new request may come together with a drop of the old one
                state    <= fetch_pkg::MC_READ;
                byte_cnt <= 3'd1;
            end else if (drop) begin
                state <= fetch_pkg::MC_IDLE;
            end else if (state == fetch_pkg::MC_READ) begin
                byte_cnt <= byte_cnt + 3'd1;
                // last byte is on rd_data now
                if (byte_cnt == 3'(fetch_pkg::INST_BYTES)) begin
                    state      <= fetch_pkg::MC_IDLE;
                    fill_valid <= 1'b1;
                end
            end
        end
    end

    // little endian, low byte shifted in first
    always_ff @(posedge clk) begin
        if (req) begin
            base_addr <= req_addr;
        end
        if (state == fetch_pkg::MC_READ) begin
            shift_word <= {rd_data, shift_word[31:8]};
        end
    end

    // fetcher keeps one request outstanding unless it cancels it
    a_req_when_free: assert property (
        @(posedge clk) disable iff (rst)
        req |-> (state == fetch_pkg::MC_IDLE || drop)
    );

endmodule

`default_nettype wire

// ==== fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // sizing
    localparam int RAM_ADDR_BITS = 12;
    localparam int ICACHE_DEPTH = 64;
    // max words the prefetch address may run ahead of pc
    localparam int PREFETCH_WINDOW = 32;
    localparam int INST_BYTES = 4;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [7:0] byte_t;
    typedef logic [RAM_ADDR_BITS-1:0] ram_addr_t;

    // address bits 7:2 select the cache line
    typedef logic [$clog2(ICACHE_DEPTH)-1:0] index_t;

    // word returned by the memory controller
    typedef struct packed {
        addr_t addr;
        inst_t inst;
    } mem_fill_t;

    // one instruction handed to dispatch
    typedef struct packed {
        addr_t pc;
        inst_t inst;
    } dispatch_t;

    typedef enum logic {
        FETCH_IDLE,
        FETCH_WAIT
    } fetch_state_t;

    typedef enum logic {
        MC_IDLE,
        MC_READ
    } mc_state_t;

endpackage

`default_nettype wire

// ==== fetch_top.sv ====
`default_nettype none

module fetch_top (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  load_en,
    input  fetch_pkg::ram_addr_t load_addr,
    input  fetch_pkg::byte_t     load_data,
    input  wire                  full,
    input  wire                  rollback,
    input  fetch_pkg::addr_t     rollback_pc,
    output logic                 issue_valid,
    output fetch_pkg::dispatch_t issue
);

    // fetcher to memory controller
    logic                 req;
    fetch_pkg::addr_t     req_addr;
    logic                 drop;

    // RAM read path
    fetch_pkg::ram_addr_t rd_addr;
    fetch_pkg::byte_t     rd_data;

    // fill goes to both the cache and the fetcher
    logic                 fill_valid;
    fetch_pkg::mem_fill_t fill;

    // cache lookup
    fetch_pkg::addr_t     lookup_pc;
    logic                 hit;
    fetch_pkg::inst_t     hit_inst;

    inst_ram u_ram (
        .clk       (clk),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    fetch_mem_ctrl u_mem_ctrl (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .req_addr   (req_addr),
        .drop       (drop),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .fill_valid (fill_valid),
        .fill       (fill)
    );

    icache u_icache (
        .clk        (clk),
        .rst        (rst),
        .lookup_pc  (lookup_pc),
        .hit        (hit),
        .hit_inst   (hit_inst),
        .fill_valid (fill_valid),
        .fill       (fill)
    );

    fetcher u_fetcher (
        .clk         (clk),
        .rst         (rst),
        .full        (full),
        .rollback    (rollback),
        .rollback_pc (rollback_pc),
        .lookup_pc   (lookup_pc),
        .hit         (hit),
        .hit_inst    (hit_inst),
        .req         (req),
        .req_addr    (req_addr),
        .drop        (drop),
        .fill_valid  (fill_valid),
        .issue_valid (issue_valid),
        .issue       (issue)
    );

endmodule

`default_nettype wire

// ==== fetcher.sv ====
`default_nettype none

module fetcher (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  full,
    input  wire                  rollback,
    input  fetch_pkg::addr_t     rollback_pc,
    output fetch_pkg::addr_t     lookup_pc,
    input  wire                  hit,
    input  fetch_pkg::inst_t     hit_inst,
    output logic                 req,
    output fetch_pkg::addr_t     req_addr,
    output logic                 drop,
    input  wire                  fill_valid,
    output logic                 issue_valid,
    output fetch_pkg::dispatch_t issue
);

    fetch_pkg::fetch_state_t state;
    fetch_pkg::addr_t        pc;
    // next word to fetch in FETCH_IDLE, word in flight in FETCH_WAIT
    fetch_pkg::addr_t        pf_addr;
    fetch_pkg::addr_t        fetch_base;
    fetch_pkg::addr_t        ahead;
    logic                    fill_done;
    logic                    win_ok;
    logic                    send;
    logic                    issue_fire;

    assign lookup_pc  = pc;
    assign fill_done  = (state == fetch_pkg::FETCH_WAIT) && fill_valid;
    assign issue_fire = hit && !full && !rollback;

    always_comb begin
        fetch_base = fill_done ? pf_addr + fetch_pkg::addr_t'(fetch_pkg::INST_BYTES)
                               : pf_addr;
        ahead = fetch_base - pc;
        // pc ran over cached lines past the prefetch point, restart at pc
        if (ahead[31]) begin
            fetch_base = pc;
            ahead      = '0;
        end
        win_ok = (ahead >> 2) < fetch_pkg::addr_t'(fetch_pkg::PREFETCH_WINDOW);
    end

    // req high in FETCH_IDLE means the request leaves this cycle
    assign send = win_ok && (fill_done || (state == fetch_pkg::FETCH_IDLE && !req));

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= fetch_pkg::FETCH_IDLE;
            pc          <= '0;
            pf_addr     <= '0;
            req         <= 1'b0;
            drop        <= 1'b0;
            issue_valid <= 1'b0;
        end else if (rollback) begin
            // redirect, cancel the read in flight and refetch at once
            state       <= fetch_pkg::FETCH_IDLE;
            pc          <= rollback_pc;
            pf_addr     <= rollback_pc;
            req         <= 1'b1;
            drop        <= 1'b1;
            issue_valid <= 1'b0;
        end else begin
            drop        <= 1'b0;
            req         <= send;
            issue_valid <= issue_fire;
            if (issue_fire) begin
                pc <= pc + fetch_pkg::addr_t'(fetch_pkg::INST_BYTES);
            end
            case (state)
                fetch_pkg::FETCH_IDLE: begin
                    if (req) begin
                        state <= fetch_pkg::FETCH_WAIT;
                    end else begin
                        pf_addr <= fetch_base;
                    end
                end
                fetch_pkg::FETCH_WAIT: begin
                    if (fill_valid) begin
                        state   <= fetch_pkg::FETCH_IDLE;
                        pf_addr <= fetch_base;
                    end
                end
                default: state <= fetch_pkg::FETCH_IDLE;
            endcase
        end
    end

    // request address and issued word
    always_ff @(posedge clk) begin
        if (rollback) begin
            req_addr <= rollback_pc;
        end else if (send) begin
            req_addr <= fetch_base;
        end
        if (issue_fire) begin
            issue <= '{pc: pc, inst: hit_inst};
        end
    end

    // rollback targets come from the ROB and must stay word aligned
    a_aligned: assert property (
        @(posedge clk) disable iff (rst)
        (pc[1:0] == 2'b00) && (pf_addr[1:0] == 2'b00)
    );

endmodule

`default_nettype wire

// ==== icache.sv ====
`default_nettype none

module icache (
    input  wire                  clk,
    input  wire                  rst,
    input  fetch_pkg::addr_t     lookup_pc,
    output logic                 hit,
    output fetch_pkg::inst_t     hit_inst,
    input  wire                  fill_valid,
    input  fetch_pkg::mem_fill_t fill
);

    logic [fetch_pkg::ICACHE_DEPTH-1:0] valid;
    fetch_pkg::addr_t tag_mem  [fetch_pkg::ICACHE_DEPTH];
    fetch_pkg::inst_t data_mem [fetch_pkg::ICACHE_DEPTH];

    fetch_pkg::index_t lookup_idx;
    fetch_pkg::index_t fill_idx;

    // word index, truncated to the line count
    assign lookup_idx = fetch_pkg::index_t'(lookup_pc >> 2);
    assign fill_idx   = fetch_pkg::index_t'(fill.addr >> 2);

    // whole address is the tag, so lines 256 bytes apart never alias
    assign hit      = valid[lookup_idx] && (tag_mem[lookup_idx] == lookup_pc);
    assign hit_inst = data_mem[lookup_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (fill_valid) begin
            valid[fill_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_valid) begin
            tag_mem[fill_idx]  <= fill.addr;
            data_mem[fill_idx] <= fill.inst;
        end
    end

endmodule

`default_nettype wire

// ==== inst_ram.sv ====
`default_nettype none

module inst_ram (
    input  wire                  clk,
    input  wire                  load_en,
    input  fetch_pkg::ram_addr_t load_addr,
    input  fetch_pkg::byte_t     load_data,
    input  fetch_pkg::ram_addr_t rd_addr,
    output fetch_pkg::byte_t     rd_data
);

    fetch_pkg::byte_t mem [1 << fetch_pkg::RAM_ADDR_BITS];

    // load port, only used while the core is held in reset
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // registered read, data one cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_fetch -f build.f
out=$(./obj_dir/Vtb_fetch) || true
echo "$out"
echo "$out" | grep -q "TESTS PASSED"

// ==== tb_fetch.sv ====
`default_nettype none

module tb_fetch;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 100;
    localparam int RAM_BYTES = 1 << fetch_pkg::RAM_ADDR_BITS;
    localparam int RESET_CYCLES = 8;
    localparam int FULL_CYCLES = 30;
    // a fill takes about six cycles
    localparam int CYCLES_PER_ISSUE = 12;
    localparam int ISSUE_COUNT = 40 + 40 + 3 * 8;
    localparam int WAIT_LIMIT = 100;
    localparam int TEST_CYCLES = RAM_BYTES + RESET_CYCLES + FULL_CYCLES
                                 + ISSUE_COUNT * CYCLES_PER_ISSUE + 100;

    logic                 clk;
    logic                 rst;
    logic                 load_en;
    fetch_pkg::ram_addr_t load_addr;
    fetch_pkg::byte_t     load_data;
    logic                 full;
    logic                 rollback;
    fetch_pkg::addr_t     rollback_pc;
    logic                 issue_valid;
    fetch_pkg::dispatch_t issue;

    // copy of what was written into the instruction RAM
    fetch_pkg::byte_t ram_mirror [RAM_BYTES];
    logic [31:0]      lfsr;
    fetch_pkg::addr_t next_pc;

    fetch_top DUT (
        .clk         (clk),
        .rst         (rst),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .full        (full),
        .rollback    (rollback),
        .rollback_pc (rollback_pc),
        .issue_valid (issue_valid),
        .issue       (issue)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // little endian join of four RAM bytes
    function automatic fetch_pkg::inst_t expected_inst(fetch_pkg::addr_t pc);
        fetch_pkg::ram_addr_t base;
        base = fetch_pkg::ram_addr_t'(pc);
        return {ram_mirror[fetch_pkg::ram_addr_t'(base + 3)],
                ram_mirror[fetch_pkg::ram_addr_t'(base + 2)],
                ram_mirror[fetch_pkg::ram_addr_t'(base + 1)],
                ram_mirror[base]};
    endfunction

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_addr(string what, fetch_pkg::addr_t got, fetch_pkg::addr_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_inst(string what, fetch_pkg::inst_t got, fetch_pkg::inst_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic require_idle(string when);
        if (issue_valid !== 1'b0) begin
            $display("an instruction was issued %s at %0t ns", when, $time);
            abort_run();
        end
    endtask

    // one byte per cycle through the load port, eight LFSR bits per byte
    task automatic load_ram();
        fetch_pkg::byte_t b;
        for (int a = 0; a < RAM_BYTES; a++) begin
            for (int i = 0; i < 8; i++) begin
                b = {lfsr[0], b[7:1]};
                lfsr = lfsr_step(lfsr);
            end
            ram_mirror[a] = b;
            @(negedge clk);
            require_idle("during reset");
            load_en = 1'b1;
            load_addr = fetch_pkg::ram_addr_t'(a);
            load_data = b;
        end
        @(negedge clk);
        require_idle("during reset");
        load_en = 1'b0;
    endtask

    task automatic wait_issue(output fetch_pkg::dispatch_t got);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!issue_valid && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!issue_valid) begin
            $display("no instruction issued within %0d cycles at %0t ns", WAIT_LIMIT, $time);
            abort_run();
        end else begin
            got = issue;
        end
    endtask

    task automatic follow_stream(int count);
        fetch_pkg::dispatch_t got;
        for (int i = 0; i < count; i++) begin
            wait_issue(got);
            check_addr("issued pc", got.pc, next_pc);
            check_inst("issued instruction", got.inst, expected_inst(next_pc));
            next_pc = next_pc + 4;
        end
    endtask

    // strobe for one cycle, nothing may issue on the following edge
    task automatic rollback_to(fetch_pkg::addr_t target);
        rollback = 1'b1;
        rollback_pc = target;
        @(negedge clk);
        rollback = 1'b0;
        require_idle("in the cycle after a rollback");
        next_pc = target;
    endtask

    task automatic reset_quiet();
        rst = 1'b1;
        load_ram();
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            require_idle("during reset");
        end
        rst = 1'b0;
        @(negedge clk);
        require_idle("in the cycle after reset release");
        next_pc = '0;
    endtask

    task automatic sequential_stream();
        follow_stream(40);
    endtask

    task automatic back_pressure();
        full = 1'b1;
        repeat (FULL_CYCLES) begin
            @(negedge clk);
            require_idle("while full is high");
        end
        full = 1'b0;
        // continues past 0x100, so cache lines get reused
        follow_stream(40);
    endtask

    task automatic forward_rollback();
        rollback_to(32'h0000_0800);
        follow_stream(8);
    endtask

    // 0x110 shares its cache index with 0x10
    task automatic alias_rollback();
        rollback_to(32'h0000_0010);
        follow_stream(8);
        rollback_to(32'h0000_0110);
        follow_stream(8);
    endtask

    initial begin
        #(TEST_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles", TEST_CYCLES);
        abort_run();
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        full = 1'b0;
        rollback = 1'b0;
        rollback_pc = '0;
        lfsr = 32'hbb57_9354;
        next_pc = '0;
        reset_quiet();
        sequential_stream();
        back_pressure();
        forward_rollback();
        alias_rollback();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
